/* design/devBus_cfg.svh */
`ifndef DEVBUS_CFG_SVH
`define DEVBUS_CFG_SVH

// Data memory window, starts at address 0
`define MEM_BASE        32'h0000_0000
`define MEM_WORDS       3072

// Timer windows, 16 bytes each
`define TIMER0_BASE     32'h0000_7F00
`define TIMER1_BASE     32'h0000_7F10

// Timer register word offsets
`define REG_CTRL        2'd0
`define REG_PRESET      2'd1
`define REG_COUNT       2'd2

// Control register bit positions
`define CTRL_EN         0
`define CTRL_MODE       1
`define CTRL_IM         3

`endif

/* design/devBusPkg.sv */
`default_nettype none

package devBusPkg;

    // Byte address on the processor data port
    typedef logic [31:0] addrT;

    // One bus word
    typedef logic [31:0] wordT;

    // One enable per byte lane, bit 0 is the low byte
    typedef logic [3:0] byteEnT;

    // Timer register word offset, taken from address bits 3:2
    typedef logic [1:0] regOffT;

    // Hardware interrupt lines 7 to 2 of the processor
    typedef logic [5:0] hwIntT;

    // Target of the current access
    typedef enum logic [1:0] {
        DEV_NONE,
        DEV_MEM,
        DEV_TIMER0,
        DEV_TIMER1
    } devSelT;

    // Timer FSM
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        COUNT,
        FIRE
    } timerStateT;

    // Timer mode as stored in control bit 1
    typedef enum logic {
        MODE_ONESHOT = 1'b0,
        MODE_RELOAD  = 1'b1
    } timerModeT;

endpackage

`default_nettype wire

/* design/dataMem.sv */
`default_nettype none
`include "devBus_cfg.svh"

module dataMem import devBusPkg::*; (
    input  wire         clk,
    input  wire addrT   memAddr,
    input  wire wordT   memWData,
    input  wire byteEnT memByteEn,
    input  wire         memWe,
    output wordT        memRData
);

    localparam int Depth = `MEM_WORDS;
    localparam int IdxW  = $clog2(Depth);

    wordT            mem [Depth];
    logic [IdxW-1:0] idx;

    // Bridge only strobes in-range addresses, upper bits are zero then
    assign idx = memAddr[IdxW-1:0];

    always_ff @(posedge clk) begin
        if (memWe) begin
            for (int i = 0; i < 4; i++) begin
                if (memByteEn[i]) begin
                    mem[idx][8*i +: 8] <= memWData[8*i +: 8];
                end
            end
        end
        // Old word on a write cycle
        memRData <= mem[idx];
    end

endmodule

`default_nettype wire

/* design/intervalTimer.sv */
`default_nettype none
`include "devBus_cfg.svh"

module intervalTimer import devBusPkg::*; (
    input  wire         clk,
    input  wire         rstN,
    input  wire regOffT regOff,
    input  wire wordT   wData,
    input  wire         we,
    output wordT        rData,
    output logic        irq
);

    logic [3:0] ctrlQ;
    wordT       presetQ;
    wordT       countQ;
    timerStateT stateQ;
    timerStateT stateD;
    timerModeT  mode;
    logic       ctrlWr;
    logic       presetWr;
    logic       fireNow;
    wordT       loadVal;

    assign ctrlWr   = we && (regOff == `REG_CTRL);
    assign presetWr = we && (regOff == `REG_PRESET);
    assign mode     = timerModeT'(ctrlQ[`CTRL_MODE]);

    // A zero preset still counts one cycle
    assign loadVal  = (presetQ == '0) ? wordT'(1) : presetQ;

    // Last decrement, count goes from 1 to 0
    assign fireNow  = (stateQ == COUNT) && ctrlQ[`CTRL_EN] && (countQ == wordT'(1));

    always_comb begin
        stateD = stateQ;
        case (stateQ)
            IDLE: begin
                if (ctrlWr && wData[`CTRL_EN]) begin
                    stateD = LOAD;
                end
            end
            LOAD: begin
                stateD = COUNT;
            end
            COUNT: begin
                if (!ctrlQ[`CTRL_EN]) begin
                    stateD = IDLE;
                end else if (fireNow) begin
                    stateD = FIRE;
                end
            end
            FIRE: begin
                if (mode == MODE_RELOAD && ctrlQ[`CTRL_EN]) begin
                    stateD = LOAD;
                end else begin
                    stateD = IDLE;
                end
            end
            default: begin
                stateD = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrlQ   <= '0;
            presetQ <= '0;
            countQ  <= '0;
            stateQ  <= IDLE;
            irq     <= 1'b0;
        end else begin
            stateQ <= stateD;

            if (presetWr) begin
                presetQ <= wData;
            end

            // Software write takes priority over the one-shot enable clear
            if (ctrlWr) begin
                ctrlQ <= wData[3:0];
            end else if (stateQ == FIRE && mode == MODE_ONESHOT) begin
                ctrlQ[`CTRL_EN] <= 1'b0;
            end

            if (stateQ == LOAD) begin
                countQ <= loadVal;
            end else if (stateQ == COUNT && ctrlQ[`CTRL_EN]) begin
                countQ <= countQ - wordT'(1);
            end

            // Sticky until the next control write
            if (ctrlWr) begin
                irq <= 1'b0;
            end else if (fireNow && ctrlQ[`CTRL_IM]) begin
                irq <= 1'b1;
            end
        end
    end

    // Registered read, shows values from before a same-cycle write
    always_ff @(posedge clk) begin
        case (regOff)
            `REG_CTRL:   rData <= {28'd0, ctrlQ};
            `REG_PRESET: rData <= presetQ;
            `REG_COUNT:  rData <= countQ;
            default:     rData <= '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/southBridge.sv */
`default_nettype none
`include "devBus_cfg.svh"

module southBridge import devBusPkg::*; (
    input  wire         clk,
    input  wire         rstN,
    // Processor data port
    input  wire addrT   addr,
    input  wire wordT   wData,
    input  wire byteEnT byteEn,
    input  wire         we,
    output wordT        rData,
    // Interrupts
    input  wire         extInt,
    output hwIntT       hwInt,
    // Data memory
    output addrT        memAddr,
    output wordT        memWData,
    output byteEnT      memByteEn,
    output logic        memWe,
    input  wire wordT   memRData,
    // Timers, shared offset and write data
    output regOffT      timerRegOff,
    output wordT        timerWData,
    output logic        timerWe0,
    output logic        timerWe1,
    input  wire wordT   timerRData0,
    input  wire wordT   timerRData1,
    input  wire         timerIrq0,
    input  wire         timerIrq1
);

    localparam addrT MemBase    = `MEM_BASE;
    localparam addrT MemBytes   = `MEM_WORDS * 4;
    localparam addrT Timer0Base = `TIMER0_BASE;
    localparam addrT Timer1Base = `TIMER1_BASE;

    addrT   memOff;
    regOffT regOff;
    logic   regOffOk;
    devSelT sel;
    devSelT selQ;

    assign memOff   = addr - MemBase;
    assign regOff   = addr[3:2];
    // Offset 3 of a timer window is a hole
    assign regOffOk = (regOff <= `REG_COUNT);

    always_comb begin
        sel = DEV_NONE;
        if (memOff < MemBytes) begin
            sel = DEV_MEM;
        end else if (addr[31:4] == Timer0Base[31:4] && regOffOk) begin
            sel = DEV_TIMER0;
        end else if (addr[31:4] == Timer1Base[31:4] && regOffOk) begin
            sel = DEV_TIMER1;
        end
    end

    // Local word index and offset, devices never see the base
    assign memAddr     = memOff >> 2;
    assign memWData    = wData;
    assign memByteEn   = byteEn;
    assign memWe       = we && (sel == DEV_MEM);

    assign timerRegOff = regOff;
    assign timerWData  = wData;
    // Timers only take full-word writes
    assign timerWe0    = we && (sel == DEV_TIMER0) && (byteEn == 4'hF);
    assign timerWe1    = we && (sel == DEV_TIMER1) && (byteEn == 4'hF);

    // Select follows the devices' one-cycle read latency
    always_ff @(posedge clk) begin
        if (!rstN) begin
            selQ <= DEV_NONE;
        end else begin
            selQ <= sel;
        end
    end

    always_comb begin
        case (selQ)
            DEV_MEM:    rData = memRData;
            DEV_TIMER0: rData = timerRData0;
            DEV_TIMER1: rData = timerRData1;
            default:    rData = '0;
        endcase
    end

    assign hwInt = {3'b000, extInt, timerIrq1, timerIrq0};

endmodule

`default_nettype wire

/* design/devBusTop.sv */
`default_nettype none

module devBusTop import devBusPkg::*; (
    input  wire         clk,
    input  wire         rstN,
    input  wire addrT   addr,
    input  wire wordT   wData,
    input  wire byteEnT byteEn,
    input  wire         we,
    input  wire         extInt,
    output wordT        rData,
    output hwIntT       hwInt
);

    // Memory side
    wire addrT   memAddr;
    wire wordT   memWData;
    wire byteEnT memByteEn;
    wire         memWe;
    wire wordT   memRData;

    // Timer side
    wire regOffT timerRegOff;
    wire wordT   timerWData;
    wire         timerWe0;
    wire         timerWe1;
    wire wordT   timerRData0;
    wire wordT   timerRData1;
    wire         timerIrq0;
    wire         timerIrq1;

    // Processor data port goes straight to the bridge
    southBridge bridge (
        .clk         (clk),
        .rstN        (rstN),
        .addr        (addr),
        .wData       (wData),
        .byteEn      (byteEn),
        .we          (we),
        .rData       (rData),
        .extInt      (extInt),
        .hwInt       (hwInt),
        .memAddr     (memAddr),
        .memWData    (memWData),
        .memByteEn   (memByteEn),
        .memWe       (memWe),
        .memRData    (memRData),
        .timerRegOff (timerRegOff),
        .timerWData  (timerWData),
        .timerWe0    (timerWe0),
        .timerWe1    (timerWe1),
        .timerRData0 (timerRData0),
        .timerRData1 (timerRData1),
        .timerIrq0   (timerIrq0),
        .timerIrq1   (timerIrq1)
    );

    dataMem mem (
        .clk       (clk),
        .memAddr   (memAddr),
        .memWData  (memWData),
        .memByteEn (memByteEn),
        .memWe     (memWe),
        .memRData  (memRData)
    );

    intervalTimer timer0 (
        .clk    (clk),
        .rstN   (rstN),
        .regOff (timerRegOff),
        .wData  (timerWData),
        .we     (timerWe0),
        .rData  (timerRData0),
        .irq    (timerIrq0)
    );

    intervalTimer timer1 (
        .clk    (clk),
        .rstN   (rstN),
        .regOff (timerRegOff),
        .wData  (timerWData),
        .we     (timerWe1),
        .rData  (timerRData1),
        .irq    (timerIrq1)
    );

endmodule

`default_nettype wire

/* tests/devBusTb.sv */
`default_nettype none
`include "devBus_cfg.svh"

module devBusTb import devBusPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ClkPeriod = 100;
    // Reset, then the budget of each test in run order, then a margin
    localparam int WatchdogCycles = 10 + 280 + 160 + 60 + 120 + 60 + 500;

    localparam addrT Timer0Base = `TIMER0_BASE;
    localparam addrT Timer1Base = `TIMER1_BASE;
    // Unmapped gap between memory and timers
    localparam addrT IdleAddr   = 32'h0000_6000;
    localparam wordT CtrlEn     = wordT'(1) << `CTRL_EN;
    localparam wordT CtrlMode   = wordT'(1) << `CTRL_MODE;
    localparam wordT CtrlIm     = wordT'(1) << `CTRL_IM;

    logic   clk = 1'b0;
    logic   rstN;
    addrT   addr;
    wordT   wData;
    byteEnT byteEn;
    logic   we;
    logic   extInt;
    wordT   rData;
    hwIntT  hwInt;

    logic [31:0] seed = 32'h6f51;
    // Expected memory words by word index
    // Words never written have no key
    wordT        model [int];
    int          errors = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;

    devBusTop UUT (
        .clk    (clk),
        .rstN   (rstN),
        .addr   (addr),
        .wData  (wData),
        .byteEn (byteEn),
        .we     (we),
        .extInt (extInt),
        .rData  (rData),
        .hwInt  (hwInt)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] nextRand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic wordT mergeBytes(wordT oldWord, wordT newWord, byteEnT be);
        wordT res;
        res = oldWord;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic failValue(string msg);
        errors++;
        $display("FAIL at %0d ns: %s", $time, msg);
    endtask

    task automatic reportTest(string name, int start);
        if (errors == start) begin
            testsPassed++;
            $display("Test %s: ok", name);
        end else begin
            testsFailed++;
            $display("Test %s: %0d errors", name, errors - start);
        end
    endtask

    // One access that the DUT takes at the following edge
    task automatic drive(addrT a, wordT d, byteEnT be, logic w);
        @(posedge clk);
        addr   <= a;
        wData  <= d;
        byteEn <= be;
        we     <= w;
    endtask

    task automatic readCheck(addrT a, wordT exp, string what);
        drive(a, '0, '0, 1'b0);
        @(posedge clk);
        @(negedge clk);
        if (rData !== exp) begin
            failValue($sformatf("%s at %h read %h, expected %h", what, a, rData, exp));
        end
    endtask

    task automatic writeMem(addrT a, wordT d, byteEnT be);
        int idx;
        idx = int'(a >> 2);
        drive(a, d, be, 1'b1);
        if (model.exists(idx)) begin
            model[idx] = mergeBytes(model[idx], d, be);
        end else if (be == 4'hF) begin
            model[idx] = d;
        end
    endtask

    task automatic checkMem(addrT a);
        if (model.exists(int'(a >> 2))) begin
            readCheck(a, model[int'(a >> 2)], "memory");
        end
    endtask

    // Edges after the last driven access until hwInt[line] is high
    // Gives -1 when the line never rises
    task automatic waitRise(int line, int limit, output int edges);
        edges = -1;
        for (int i = 0; i < limit; i++) begin
            drive(IdleAddr, '0, '0, 1'b0);
            @(negedge clk);
            if (hwInt[5:3] !== 3'b000) begin
                failValue($sformatf("hwInt upper bits are %b", hwInt[5:3]));
            end
            if (hwInt[line] === 1'b1) begin
                edges = i;
                break;
            end
        end
    endtask

    task automatic memByteWrites();
        int   start;
        int   idx;
        addrT a;
        addrT written [$];
        start = errors;
        for (int i = 0; i < 64; i++) begin
            idx = nextRand() % `MEM_WORDS;
            a = addrT'(idx) << 2;
            writeMem(a, nextRand(), 4'hF);
            written.push_back(a);
            checkMem(a);
        end
        // Partial rewrites of words already known
        for (int i = 0; i < 16; i++) begin
            a = written[nextRand() % 64];
            writeMem(a, nextRand(), byteEnT'(nextRand()));
            checkMem(a);
        end
        reportTest("memory byte writes", start);
    endtask

    task automatic unmappedAndLatency();
        int   start;
        addrT a;
        start = errors;
        writeMem('0, 32'h1234_5678, 4'hF);
        writeMem('0, 32'h9ABC_DEF0, 4'hF);
        drive(IdleAddr, '0, '0, 1'b0);
        @(negedge clk);
        // Word from before the write
        if (rData !== 32'h1234_5678) begin
            failValue($sformatf("read during write gave %h, expected 12345678", rData));
        end
        checkMem('0);
        for (int i = 0; i < 8; i++) begin
            a = 32'h3000 + ((nextRand() % (32'h7F00 - 32'h3000)) & ~32'h3);
            readCheck(a, '0, "gap");
            readCheck(nextRand() | 32'h0001_0000, '0, "high space");
        end
        readCheck(32'h0000_7F0C, '0, "timer 0 hole");
        readCheck(32'h0000_7F1C, '0, "timer 1 hole");
        readCheck(32'hFFFF_FFFC, '0, "top word");
        // Would alias word 0 or a timer register on a partial decode
        drive(32'h0001_0000, 32'hFFFF_FFFF, 4'hF, 1'b1);
        drive(32'h0000_7F24, 32'h55, 4'hF, 1'b1);
        drive(32'h0001_7F00, CtrlEn | CtrlIm, 4'hF, 1'b1);
        checkMem('0);
        readCheck(Timer0Base, '0, "timer 0 CTRL");
        readCheck(Timer0Base + 4, '0, "timer 0 PRESET");
        readCheck(Timer1Base + 4, '0, "timer 1 PRESET");
        reportTest("unmapped space and read latency", start);
    endtask

    task automatic timerOneShot();
        int start;
        int edges;
        start = errors;
        drive(Timer0Base + 4, 32'd5, 4'hF, 1'b1);
        drive(Timer0Base, CtrlEn | CtrlIm, 4'hF, 1'b1);
        waitRise(0, 20, edges);
        if (edges < 0) begin
            errors++;
            $display("Timer 0 interrupt did not rise within 20 cycles");
        end else if (edges != 1 + 5) begin
            failValue($sformatf("timer 0 fired after %0d edges, expected 6", edges));
        end
        readCheck(Timer0Base + 8, '0, "timer 0 COUNT");
        // One-shot clears the enable and keeps the mask
        readCheck(Timer0Base, CtrlIm, "timer 0 CTRL");
        if (hwInt[0] !== 1'b1) begin
            failValue("timer 0 interrupt dropped before a CTRL write");
        end
        drive(Timer0Base, '0, 4'hF, 1'b1);
        drive(IdleAddr, '0, '0, 1'b0);
        @(negedge clk);
        if (hwInt[0] !== 1'b0) begin
            failValue("timer 0 interrupt still high after CTRL write");
        end
        reportTest("timer one-shot", start);
    endtask

    task automatic timerReload();
        int start;
        int edges;
        start = errors;
        drive(Timer1Base + 4, 32'd3, 4'hF, 1'b1);
        drive(Timer1Base, CtrlEn | CtrlMode | CtrlIm, 4'hF, 1'b1);
        waitRise(1, 20, edges);
        if (edges != 1 + 3) begin
            failValue($sformatf("timer 1 first rise after %0d edges, expected 4", edges));
        end
        for (int r = 0; r < 3; r++) begin
            // Reload period is P+2 edges and the clear lands 2 edges into it
            drive(Timer1Base, CtrlEn | CtrlMode | CtrlIm, 4'hF, 1'b1);
            waitRise(1, 20, edges);
            if (edges != 3) begin
                failValue($sformatf("timer 1 rise %0d after %0d edges, expected 3", r, edges));
            end
            if (hwInt[0] !== 1'b0) begin
                failValue("timer 0 interrupt raised by timer 1");
            end
        end
        drive(Timer1Base, '0, 4'hF, 1'b1);
        drive(Timer1Base, CtrlEn | CtrlMode | CtrlIm, 4'h7, 1'b1);
        readCheck(Timer1Base, '0, "timer 1 CTRL after partial write");
        drive(Timer1Base + 4, 32'd9, 4'h1, 1'b1);
        readCheck(Timer1Base + 4, 32'd3, "timer 1 PRESET after partial write");
        if (hwInt[1:0] !== 2'b00) begin
            failValue($sformatf("timer interrupts %b after stop", hwInt[1:0]));
        end
        readCheck(Timer0Base, '0, "timer 0 CTRL");
        readCheck(Timer0Base + 4, 32'd5, "timer 0 PRESET");
        reportTest("timer reload and isolation", start);
    endtask

    task automatic interruptVector();
        int start;
        int edges;
        start = errors;
        @(posedge clk);
        extInt <= 1'b1;
        @(negedge clk);
        if (hwInt !== 6'b000100) begin
            failValue($sformatf("hwInt %b with extInt high, expected 000100", hwInt));
        end
        @(posedge clk);
        extInt <= 1'b0;
        @(negedge clk);
        if (hwInt !== 6'b000000) begin
            failValue($sformatf("hwInt %b with extInt low, expected 000000", hwInt));
        end
        // Timer 1 count is frozen at 3, so a zero count shows it ran down
        // Reaching zero with the mask clear raises nothing
        drive(Timer1Base + 4, 32'd2, 4'hF, 1'b1);
        drive(Timer1Base, CtrlEn, 4'hF, 1'b1);
        waitRise(1, 10, edges);
        if (edges >= 0) begin
            failValue("timer 1 interrupt rose with the mask clear");
        end
        readCheck(Timer1Base + 8, '0, "timer 1 COUNT");
        readCheck(Timer1Base, '0, "timer 1 CTRL");
        reportTest("interrupt vector", start);
    endtask

    initial begin
        rstN   = 1'b0;
        addr   = '0;
        wData  = '0;
        byteEn = '0;
        we     = 1'b0;
        extInt = 1'b0;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;

        memByteWrites();
        unmappedAndLatency();
        timerOneShot();
        timerReload();
        interruptVector();

        $display("Tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("The run did not finish within %0d cycles", WatchdogCycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* devBusTop.f */
+incdir+design
design/devBusPkg.sv
design/dataMem.sv
design/intervalTimer.sv
design/southBridge.sv
design/devBusTop.sv
tests/devBusTb.sv

/* Bender.yml */
package:
  name: devBus

sources:
  - include_dirs:
      - design
    files:
      - design/devBusPkg.sv
      - design/dataMem.sv
      - design/intervalTimer.sv
      - design/southBridge.sv
      - design/devBusTop.sv

  - target: test
    include_dirs:
      - design
    files:
      - tests/devBusTb.sv
